// File: verilog/spi_bridge_settings.svh
`ifndef SPI_BRIDGE_SETTINGS_SVH
`define SPI_BRIDGE_SETTINGS_SVH

// --------------------
// FIFO sizing.
// --------------------

// Log2 of the depth of both clock-crossing FIFOs.
`define SB_FIFO_ABITS 2

// --------------------
// Frame bytes.
// --------------------

// First byte on MISO in every frame.
`define SB_HEADER_BYTE 8'hA7
// Second byte on MISO, prefetched before the command is known.
`define SB_STATUS_BYTE 8'h00

// Log2 of the register memory depth (64 bytes).
`define SB_MEM_ABITS 6

`endif

// File: verilog/spi_bridge_pkg.sv
`include "spi_bridge_settings.svh"

package spi_bridge_pkg;

   // --------------------
   // Data widths.
   // --------------------

   // One SPI or bus data byte.
   typedef logic [7:0] byte_t;

   // Address field of the command byte.
   typedef logic [6:0] addr_t;

   // FIFO pointer, with the extra wrap bit.
   typedef logic [`SB_FIFO_ABITS:0] ptr_t;

   // --------------------
   // Regfile frame FSM.
   // --------------------
   typedef enum logic [2:0] {
      RF_IDLE,
      RF_STATUS,
      RF_CMD,
      RF_READ,
      RF_WRITE
   } rf_state_t;

endpackage

// File: verilog/afifo_gray.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module afifo_gray
   import spi_bridge_pkg::*;
(
   input  logic  wr_clk_i,
   input  logic  wr_en_i,
   input  byte_t wr_data_i,
   output logic  wfull_o,
   input  logic  rd_clk_i,
   input  logic  rd_en_i,
   output byte_t rd_data_o,
   output logic  rempty_o,
   input  logic  rst_i
);

   localparam int AB    = `SB_FIFO_ABITS;
   localparam int DEPTH = 1 << AB;

   byte_t mem [DEPTH];

   // Pointers in their own domains.
   ptr_t wr_bin;
   ptr_t wr_gray;
   ptr_t rd_bin;
   ptr_t rd_gray;
   ptr_t wr_bin_next;
   ptr_t rd_bin_next;

   // Gray pointers after the two-flop crossing.
   ptr_t wr_gray_m;
   ptr_t wr_gray_s;
   ptr_t rd_gray_m;
   ptr_t rd_gray_s;

   logic do_write;
   logic do_read;

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   // Writes when full and reads when empty are dropped.
   assign do_write    = wr_en_i && !wfull_o;
   assign do_read     = rd_en_i && !rempty_o;
   assign wr_bin_next = wr_bin + ptr_t'(do_write);
   assign rd_bin_next = rd_bin + ptr_t'(do_read);

   // --------------------
   // Write domain.
   // --------------------
   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= bin2gray(wr_bin_next);
      end
   end

   always_ff @(posedge wr_clk_i) begin
      if (do_write) begin
         mem[wr_bin[AB-1:0]] <= wr_data_i;
      end
   end

   // Read pointer into the write domain.
   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_gray_m <= '0;
         rd_gray_s <= '0;
      end else begin
         rd_gray_m <= rd_gray;
         rd_gray_s <= rd_gray_m;
      end
   end

   // Full when the top two Gray bits differ and the rest match.
   assign wfull_o = (wr_gray == {~rd_gray_s[AB:AB-1], rd_gray_s[AB-2:0]});

   // --------------------
   // Read domain.
   // --------------------
   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= bin2gray(rd_bin_next);
      end
   end

   // Write pointer into the read domain.
   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_gray_m <= '0;
         wr_gray_s <= '0;
      end else begin
         wr_gray_m <= wr_gray;
         wr_gray_s <= wr_gray_m;
      end
   end

   assign rempty_o = (rd_gray == wr_gray_s);

   // Head entry, shown without a register stage.
   assign rd_data_o = mem[rd_bin[AB-1:0]];

endmodule

// File: verilog/spi_layer.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module spi_layer
   import spi_bridge_pkg::*;
(
   input  logic  clk_i,
   input  logic  SSEL,
   input  logic  sck_i,
   input  logic  mosi_i,
   output logic  miso_o,
   output logic  cyc_o,
   output logic  get_o,
   input  logic  rdy_i,
   input  byte_t wdat_i,
   output logic  wat_o,
   input  logic  ack_i,
   output byte_t rdat_o,
   output logic  overflow_o,
   output logic  underrun_o
);

   localparam byte_t HEADER = `SB_HEADER_BYTE;

   // TX side runs on the falling SCK edge.
   logic       sck_tx;

   logic [2:0] rx_count;
   logic [6:0] rx_reg;
   byte_t      rx_data;
   logic       rx_push;
   logic       rx_full;
   logic       rx_empty;

   logic [2:0] tx_count;
   logic [6:0] tx_reg;
   byte_t      tx_data;
   logic       tx_next;
   logic       tx_pull;
   logic       tx_empty;
   logic       tx_flush;

   logic       spi_req;
   logic       req_meta;
   logic       req_sync;
   logic       req_last;
   logic       req_edge;

   logic       sel_meta;
   logic       sel_sync;

   assign sck_tx = ~sck_i;

   // --------------------
   // Slave select sync.
   // --------------------

   // Deselect clears at once, select passes two flops.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         sel_meta <= 1'b0;
         sel_sync <= 1'b0;
      end else begin
         sel_meta <= 1'b1;
         sel_sync <= sel_meta;
      end
   end

   assign cyc_o = sel_sync;
   assign wat_o = rx_empty;

   // --------------------
   // Prefetch request.
   // --------------------

   // High for one SCK period after the first edge of each byte.
   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         spi_req <= 1'b0;
      end else begin
         spi_req <= (rx_count == 3'd0);
      end
   end

   // Bring the request into clk_i and keep its rising edge only.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         req_meta <= 1'b0;
         req_sync <= 1'b0;
         req_last <= 1'b0;
      end else begin
         req_meta <= spi_req;
         req_sync <= req_meta;
         req_last <= req_sync;
      end
   end

   assign req_edge = req_sync && !req_last;

   // Get holds until the slave answers.
   // A new request wins over a late rdy.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         get_o <= 1'b0;
      end else if (req_edge) begin
         get_o <= 1'b1;
      end else if (rdy_i) begin
         get_o <= 1'b0;
      end
   end

   // Flush of the TX FIFO, held through deselect.
   // Released on the first clk_i edge of a frame.
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         tx_flush <= 1'b1;
      end else begin
         tx_flush <= 1'b0;
      end
   end

   // --------------------
   // Receive path.
   // --------------------

   // MSB first, sampled on rising SCK.
   always_ff @(posedge sck_i) begin
      rx_reg <= {rx_reg[5:0], mosi_i};
   end

   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         rx_count <= 3'd0;
      end else begin
         rx_count <= rx_count + 3'd1;
      end
   end

   // The eighth bit goes straight into the FIFO with the other seven.
   assign rx_push = (rx_count == 3'd7);
   assign rx_data = {rx_reg, mosi_i};

   // Byte dropped on a full RX FIFO.
   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         overflow_o <= 1'b0;
      end else if (rx_push && rx_full) begin
         overflow_o <= 1'b1;
      end
   end

   // --------------------
   // Transmit path.
   // --------------------
   assign tx_next = (tx_count == 3'd7);

   // Header waits in the shifter while deselected.
   // At each byte boundary the FIFO head is loaded.
   always_ff @(posedge sck_tx or posedge SSEL) begin
      if (SSEL) begin
         tx_reg   <= HEADER[6:0];
         miso_o   <= HEADER[7];
         tx_count <= 3'd0;
         tx_pull  <= 1'b0;
      end else begin
         tx_count <= tx_count + 3'd1;
         // Pop one edge late, so the final edge of a frame pulls nothing.
         tx_pull  <= tx_next;
         if (tx_next) begin
            tx_reg <= tx_data[6:0];
            miso_o <= tx_data[7];
         end else begin
            tx_reg <= {tx_reg[5:0], 1'b0};
            miso_o <= tx_reg[6];
         end
      end
   end

   // Nothing prefetched for the byte just started.
   always_ff @(posedge sck_tx or posedge SSEL) begin
      if (SSEL) begin
         underrun_o <= 1'b0;
      end else if (tx_pull && tx_empty) begin
         underrun_o <= 1'b1;
      end
   end

   // --------------------
   // Clock-crossing FIFOs.
   // --------------------
   afifo_gray tx_fifo (
      .wr_clk_i  (clk_i),
      .wr_en_i   (rdy_i),
      .wr_data_i (wdat_i),
      .wfull_o   (),
      .rd_clk_i  (sck_tx),
      .rd_en_i   (tx_pull),
      .rd_data_o (tx_data),
      .rempty_o  (tx_empty),
      .rst_i     (tx_flush)
   );

   afifo_gray rx_fifo (
      .wr_clk_i  (sck_i),
      .wr_en_i   (rx_push),
      .wr_data_i (rx_data),
      .wfull_o   (rx_full),
      .rd_clk_i  (clk_i),
      .rd_en_i   (ack_i),
      .rd_data_o (rdat_o),
      .rempty_o  (rx_empty),
      .rst_i     (SSEL)
   );

endmodule

// File: verilog/spi_regfile.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module spi_regfile
   import spi_bridge_pkg::*;
(
   input  logic  clk_i,
   input  logic  SSEL,
   input  logic  cyc_i,
   input  logic  get_i,
   output logic  rdy_o,
   output byte_t wdat_o,
   input  logic  wat_i,
   output logic  ack_o,
   input  byte_t rdat_i
);

   localparam int MEM_DEPTH = 1 << `SB_MEM_ABITS;

   byte_t mem [MEM_DEPTH];

   rf_state_t state;
   addr_t     addr;
   logic      in_range;
   logic      get_new;
   logic [`SB_MEM_ABITS-1:0] idx;

   assign idx      = addr[`SB_MEM_ABITS-1:0];
   assign in_range = (int'(addr) < MEM_DEPTH);

   // Request not yet answered.
   // Stops a second rdy while get is still high.
   assign get_new = get_i && !rdy_o;

   // --------------------
   // RX pop.
   // --------------------

   // Pop as soon as a byte shows once the header is served.
   // Read frames discard what they pop.
   always_comb begin
      case (state)
         RF_CMD, RF_READ, RF_WRITE: ack_o = !wat_i;
         default: ack_o = 1'b0;
      endcase
   end

   // --------------------
   // Frame FSM.
   // --------------------
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state <= RF_IDLE;
         addr  <= '0;
         rdy_o <= 1'b0;
      end else if (!cyc_i) begin
         state <= RF_IDLE;
         rdy_o <= 1'b0;
      end else begin
         rdy_o <= 1'b0;
         case (state)
            RF_IDLE: begin
               state <= RF_STATUS;
            end
            RF_STATUS: begin
               // First prefetch gets the status byte.
               if (get_new) begin
                  rdy_o <= 1'b1;
                  state <= RF_CMD;
               end
            end
            RF_CMD: begin
               // Any pending get waits for the command.
               if (ack_o) begin
                  addr  <= rdat_i[6:0];
                  state <= rdat_i[7] ? RF_WRITE : RF_READ;
               end
            end
            RF_READ: begin
               // Past the end the request stays unanswered.
               if (get_new && in_range) begin
                  rdy_o <= 1'b1;
                  addr  <= addr + 7'd1;
               end
            end
            RF_WRITE: begin
               // Prefetches still need a byte to keep MISO fed.
               if (get_new) begin
                  rdy_o <= 1'b1;
               end
               if (ack_o && in_range) begin
                  addr <= addr + 7'd1;
               end
            end
            default: begin
               state <= RF_IDLE;
            end
         endcase
      end
   end

   // --------------------
   // Data paths.
   // --------------------

   // Ready with rdy on the same edge, at the old address.
   always_ff @(posedge clk_i) begin
      if (state == RF_READ) begin
         wdat_o <= mem[idx];
      end else begin
         wdat_o <= `SB_STATUS_BYTE;
      end
   end

   // Out-of-range writes are dropped.
   always_ff @(posedge clk_i) begin
      if (state == RF_WRITE && ack_o && in_range) begin
         mem[idx] <= rdat_i;
      end
   end

endmodule

// File: verilog/spi_bridge.sv
`timescale 1ns/1ps

module spi_bridge
   import spi_bridge_pkg::*;
(
   input  logic clk_i,
   input  logic SSEL,
   input  logic sck_i,
   input  logic mosi_i,
   output logic miso_o,
   output logic overflow_o,
   output logic underrun_o
);

   // --------------------
   // Internal bus.
   // --------------------
   logic  cyc;
   logic  get;
   logic  rdy;
   logic  wat;
   logic  ack;
   byte_t wdat;
   byte_t rdat;

   // SPI side and bus master.
   spi_layer u_layer (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .sck_i      (sck_i),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .cyc_o      (cyc),
      .get_o      (get),
      .rdy_i      (rdy),
      .wdat_i     (wdat),
      .wat_o      (wat),
      .ack_i      (ack),
      .rdat_o     (rdat),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   // Register memory as bus slave.
   spi_regfile u_regfile (
      .clk_i  (clk_i),
      .SSEL   (SSEL),
      .cyc_i  (cyc),
      .get_i  (get),
      .rdy_o  (rdy),
      .wdat_o (wdat),
      .wat_i  (wat),
      .ack_o  (ack),
      .rdat_i (rdat)
   );

endmodule

// File: testbench/spi_bridge_assert.sv
`timescale 1ns/1ps

module spi_bridge_assert (
   input logic clk_i,
   input logic SSEL,
   input logic cyc_i,
   input logic get_i,
   input logic rdy_i,
   input logic wat_i,
   input logic ack_i,
   input logic overflow_i,
   input logic underrun_i
);

   // Number of assertion failures so far.
   int fail_count = 0;

   // --------------------
   // Bus handshake.
   // --------------------

   // A pop needs a byte at the RX FIFO head.
   ack_with_data: assert property (@(posedge clk_i) disable iff (SSEL)
      ack_i |-> !wat_i)
      else begin
         fail_count++;
         $error("ack raised while the RX FIFO is empty");
      end

   // The slave answers only an open request.
   rdy_with_get: assert property (@(posedge clk_i) disable iff (SSEL)
      rdy_i |-> get_i)
      else begin
         fail_count++;
         $error("rdy raised without a pending get");
      end

   // --------------------
   // Select and flags.
   // --------------------

   // Deselect closes the bus cycle quickly.
   cyc_drops: assert property (@(posedge clk_i)
      SSEL |-> ##[0:3] !cyc_i)
      else begin
         fail_count++;
         $error("cyc still high 3 cycles after deselect");
      end

   // Everything idle while deselected.
   idle_in_reset: assert property (@(posedge clk_i)
      SSEL |-> !get_i && !rdy_i && !ack_i && !overflow_i && !underrun_i)
      else begin
         fail_count++;
         $error("bus or error flags active during deselect");
      end

endmodule

// Watch the bus at the master side.
bind spi_layer spi_bridge_assert u_assert (
   .clk_i      (clk_i),
   .SSEL       (SSEL),
   .cyc_i      (cyc_o),
   .get_i      (get_o),
   .rdy_i      (rdy_i),
   .wat_i      (wat_o),
   .ack_i      (ack_i),
   .overflow_i (overflow_o),
   .underrun_i (underrun_o)
);

// File: testbench/tb_spi_bridge.sv
`timescale 1ns/1ps
`include "spi_bridge_settings.svh"

module tb_spi_bridge
   import spi_bridge_pkg::*;
();

   localparam int    HALF      = 5;
   localparam int    GAP       = 10;
   localparam int    PAT_WORDS = 512;
   localparam int    MEM_DEPTH = 1 << `SB_MEM_ABITS;
   localparam byte_t HEADER    = `SB_HEADER_BYTE;
   localparam byte_t STATUS    = `SB_STATUS_BYTE;

   logic clk_i;
   logic SSEL;
   logic sck_i;
   logic mosi_i;
   logic miso_o;
   logic overflow_o;
   logic underrun_o;

   byte_t       pat_mem [PAT_WORDS];
   int          starts[$];
   logic [31:0] lfsr;
   int          byte_errors  = 0;
   int          flag_errors  = 0;
   int          other_errors = 0;
   int          cycle_count  = 0;
   int          cycle_limit  = 1000;
   int          pos;

   spi_bridge DUT (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .sck_i      (sck_i),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // --------------------
   // Helpers.
   // --------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One LFSR step per filler bit.
   task automatic pad_byte(output byte_t b);
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         b    = {b[6:0], lfsr[0]};
      end
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t got);
      if (got !== exp) begin
         byte_errors++;
         $display("mismatch %0t %s expected %02h got %02h", $time, name, exp, got);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         flag_errors++;
         $display("mismatch %0t %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   // Upper bound of one frame in clk_i cycles.
   function automatic int frame_cycles(input int count);
      return (count + 2) * 16 * HALF + HALF + GAP;
   endfunction

   task automatic print_counts();
      $display("errors: bytes=%0d flags=%0d other=%0d assertions=%0d",
               byte_errors, flag_errors, other_errors, DUT.u_layer.u_assert.fail_count);
   endtask

   // --------------------
   // SPI master, mode 0.
   // --------------------

   // MOSI set while SCK is low, MISO read just before the rising edge.
   task automatic xfer_byte(input byte_t tx, output byte_t rx);
      for (int i = 7; i >= 0; i--) begin
         mosi_i = tx[i];
         wait_cycles(HALF);
         rx[i] = miso_o;
         sck_i = 1'b1;
         wait_cycles(HALF);
         sck_i = 1'b0;
      end
   endtask

   // One frame from the record at word base.
   task automatic run_frame(input int base);
      addr_t addr;
      int    count;
      int    nbytes;
      int    d;
      logic  is_write;
      logic  past_end;
      byte_t tx;
      byte_t rx;

      addr     = pat_mem[base + 1][6:0];
      count    = int'(pat_mem[base + 2]);
      is_write = pat_mem[base][0];
      // Reads beyond the last address leave the TX FIFO dry.
      past_end = !is_write && (int'(addr) + count > MEM_DEPTH);
      nbytes   = is_write ? count + 1 : count + 2;

      SSEL = 1'b0;
      xfer_byte({is_write, addr}, rx);
      check_byte("miso header", HEADER, rx);
      check_flag("underrun_o at frame start", 1'b0, underrun_o);
      for (int i = 1; i < nbytes; i++) begin
         if (is_write) begin
            tx = pat_mem[base + 2 + i];
         end else begin
            pad_byte(tx);
         end
         xfer_byte(tx, rx);
         if (i == 1) begin
            check_byte("miso status", STATUS, rx);
         end
         // Read data starts at the third byte.
         d = i - 2;
         if (!is_write && d >= 0 && int'(addr) + d < MEM_DEPTH) begin
            check_byte($sformatf("mem[%0d]", int'(addr) + d), pat_mem[base + 3 + d], rx);
         end
      end
      // Let the last RX byte reach memory before deselect.
      wait_cycles(HALF);
      check_flag("overflow_o", 1'b0, overflow_o);
      check_flag("underrun_o", past_end, underrun_o);
      SSEL = 1'b1;
      wait_cycles(GAP);
   endtask

   // --------------------
   // Run limit.
   // --------------------
   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("timeout: frames did not complete");
         print_counts();
         $display("=== FAIL ===");
         $finish;
      end
   end

   // --------------------
   // Main sequence.
   // --------------------
   initial begin
      SSEL   = 1'b0;
      sck_i  = 1'b0;
      mosi_i = 1'b0;
      lfsr   = 32'h9440;
      $readmemh("testbench/spi_bridge_patterns.txt", pat_mem);

      // Scan the records and size the run.
      pos         = 0;
      cycle_limit = 16 + 500;
      while (pos + 2 < PAT_WORDS && pat_mem[pos] !== 8'hFF) begin
         if (pat_mem[pos] !== 8'h00 && pat_mem[pos] !== 8'h01) begin
            other_errors++;
            $display("pattern file has a bad direction at word %0d", pos);
            break;
         end
         if (pos + 3 + int'(pat_mem[pos + 2]) > PAT_WORDS) begin
            other_errors++;
            $display("pattern record at word %0d runs past the end", pos);
            break;
         end
         starts.push_back(pos);
         cycle_limit += frame_cycles(int'(pat_mem[pos + 2]));
         pos += 3 + int'(pat_mem[pos + 2]);
      end
      if (starts.size() == 0) begin
         other_errors++;
         $display("no frames found in the pattern file");
      end

      // Deselect doubles as reset.
      // Its rising edge clears the SCK-domain flops too.
      @(negedge clk_i);
      SSEL = 1'b1;
      wait_cycles(16);
      check_flag("miso_o after reset", HEADER[7], miso_o);
      check_flag("overflow_o after reset", 1'b0, overflow_o);
      check_flag("underrun_o after reset", 1'b0, underrun_o);

      foreach (starts[i]) begin
         run_frame(starts[i]);
      end

      print_counts();
      if (byte_errors + flag_errors + other_errors + DUT.u_layer.u_assert.fail_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+verilog
verilog/spi_bridge_pkg.sv
verilog/afifo_gray.sv
verilog/spi_layer.sv
verilog/spi_regfile.sv
verilog/spi_bridge.sv
testbench/spi_bridge_assert.sv
testbench/tb_spi_bridge.sv

// File: Bender.yml
package:
  name: spi_bridge

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/spi_bridge_pkg.sv
      - verilog/afifo_gray.sv
      - verilog/spi_layer.sv
      - verilog/spi_regfile.sv
      - verilog/spi_bridge.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/spi_bridge_assert.sv
      - testbench/tb_spi_bridge.sv

// File: testbench/spi_bridge_patterns.txt
// Columns: dir (01 write, 00 read, FF ends the list), addr, count, then count bytes.
// Write rows give MOSI data, read rows the expected data; bytes past the memory end are fillers.
01 00 04 11 22 33 44
00 00 04 11 22 33 44
01 10 08 A0 A1 A2 A3 A4 A5 A6 A7
00 10 08 A0 A1 A2 A3 A4 A5 A6 A7
00 12 03 A2 A3 A4
00 16 02 A6 A7
01 20 01 5C
00 20 01 5C
01 02 02 99 88
00 00 04 11 22 99 88
01 28 10 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
00 28 10 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
00 30 06 08 09 0A 0B 0C 0D
01 3E 02 E1 E2
00 3E 04 E1 E2 00 00
00 3F 01 E2
00 00 02 11 22
FF
